/* verilog/periph_xbar_pkg.sv */
/*
 * periph_xbar_pkg
 * Sizes, cluster address map, target indices and the request and response
 * payload structs shared by the peripheral interconnect.
 */

package periph_xbar_pkg;

  // initiators: cores first, then master peripheral ports
  localparam int unsigned NB_CORES    = 3;
  localparam int unsigned NB_MPERIPHS = 1;
  localparam int unsigned NB_INPS     = NB_CORES + NB_MPERIPHS;
  localparam int unsigned NB_TGTS     = 8;
  localparam int unsigned INP_IDX_W   = $clog2(NB_INPS);

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = 4;

  // peripheral select field inside the window
  localparam int unsigned ROUTE_LSB = 10;
  localparam int unsigned ROUTE_MSB = 13;

  // cluster map, each cluster id adds a 4 MiB step to the base
  localparam logic [ADDR_W-1:0] CLUSTER_BASE = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] PERIPH_OFFS  = 32'h0020_0000;
  localparam logic [ADDR_W-1:0] EXT_OFFS     = 32'h0040_0000;

  localparam bit          ALIAS_EN  = 1'b1;
  localparam logic [7:0]  ALIAS_TOP = 8'h1B;

  typedef logic [$clog2(NB_TGTS)-1:0] tgt_idx_t;
  typedef logic [NB_INPS-1:0]         init_id_t;

  // target map
  localparam tgt_idx_t    TGT_EVENT_ID = 3'd2;
  localparam int unsigned EU_PLUGS     = 2;
  localparam tgt_idx_t    TGT_HWPE_ID  = 3'd5;
  localparam bit          HWPE_PRESENT = 1'b0;
  localparam tgt_idx_t    TGT_EXT_ID   = 3'd6;
  localparam tgt_idx_t    TGT_ERR_ID   = 3'd7;

  // 73 bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    init_id_t          id;
    logic              we_n;  // low for a write
    logic [BE_W-1:0]   be;
  } periph_req_t;

  // 37 bits
  typedef struct packed {
    logic [DATA_W-1:0] data;
    init_id_t          id;
    logic              opc;
  } periph_rsp_t;

endpackage

/* verilog/periph_req_router.sv */
/*
 * periph_req_router
 * Decodes one initiator's address to a single target and steers the
 * request to it. The grant of the chosen target is returned to the initiator.
 */

`timescale 1ns/1ps

module periph_req_router
  import periph_xbar_pkg::*;
(
  input  logic [ADDR_W-1:0]  periph_base_i,
  input  logic [ADDR_W-1:0]  periph_end_i,
  input  logic [7:0]         cluster_top_i,
  input  logic               req_i,
  input  logic [ADDR_W-1:0]  addr_i,
  input  logic [NB_TGTS-1:0] tgt_gnt_i,
  output logic [NB_TGTS-1:0] tgt_req_o,
  output logic               gnt_o
);

  logic [ROUTE_MSB-ROUTE_LSB:0] raw_idx;
  logic                         in_cluster;
  logic                         in_window;
  logic                         well_formed;
  tgt_idx_t                     tgt_sel;

  assign raw_idx = addr_i[ROUTE_MSB:ROUTE_LSB];

  // own cluster or the alias region
  assign in_cluster = (addr_i[31:24] == cluster_top_i) ||
                      (ALIAS_EN && (addr_i[31:24] == ALIAS_TOP));

  assign in_window = (addr_i >= periph_base_i) && (addr_i <= periph_end_i);

  // upper bits must point at the peripheral block, unused bits zero
  assign well_formed = (addr_i[31:20] == periph_base_i[31:20]) &&
                       (addr_i[19:ROUTE_MSB+1] == '0) &&
                       (raw_idx < NB_TGTS);

  always_comb begin
    if (!(in_cluster && in_window)) begin
      tgt_sel = TGT_EXT_ID;
    end else if (!well_formed) begin
      tgt_sel = TGT_ERR_ID;
    end else if ((raw_idx >= TGT_EVENT_ID) && (raw_idx < TGT_EVENT_ID + EU_PLUGS)) begin
      // both event unit plugs share one port
      tgt_sel = TGT_EVENT_ID;
    end else if (!HWPE_PRESENT && (tgt_idx_t'(raw_idx) == TGT_HWPE_ID)) begin
      tgt_sel = TGT_ERR_ID;
    end else if (tgt_idx_t'(raw_idx) == TGT_EXT_ID) begin
      // a direct hit on the external port would loop back out of the cluster
      tgt_sel = TGT_ERR_ID;
    end else begin
      tgt_sel = tgt_idx_t'(raw_idx);
    end
  end

  // one-hot request toward the selected target only
  always_comb begin
    tgt_req_o = '0;
    tgt_req_o[tgt_sel] = req_i;
  end

  assign gnt_o = tgt_gnt_i[tgt_sel];

endmodule

/* verilog/periph_rr_arb.sv */
/*
 * periph_rr_arb
 * Round-robin arbiter in front of one target. Picks the first requesting
 * initiator at or after the priority pointer and forwards its request.
 */

`timescale 1ns/1ps

module periph_rr_arb
  import periph_xbar_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic        [NB_INPS-1:0] req_i,
  input  periph_req_t [NB_INPS-1:0] data_i,
  input  logic                      gnt_i,
  output logic        [NB_INPS-1:0] gnt_o,
  output logic                      req_o,
  output periph_req_t               data_o
);

  logic [INP_IDX_W-1:0] ptr_q;
  logic [INP_IDX_W-1:0] win;
  logic [INP_IDX_W-1:0] ptr_nxt;
  logic                 found;

  // scan from the pointer, wrapping around once
  always_comb begin
    int unsigned cand;
    found = 1'b0;
    win   = ptr_q;
    for (int unsigned k = 0; k < NB_INPS; k++) begin
      cand = (int'(ptr_q) + k) % NB_INPS;
      if (!found && req_i[cand]) begin
        found = 1'b1;
        win   = INP_IDX_W'(cand);
      end
    end
  end

  assign req_o  = found;
  assign data_o = data_i[win];

  // only the winner sees the target's grant
  always_comb begin
    gnt_o = '0;
    gnt_o[win] = found & gnt_i;
  end

  assign ptr_nxt = (win == INP_IDX_W'(NB_INPS - 1)) ? '0 : win + 1'b1;

  // pointer moves past the winner only on a completed handshake
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (req_o && gnt_i) begin
      ptr_q <= ptr_nxt;
    end
  end

endmodule

/* verilog/periph_resp_mux.sv */
/*
 * periph_resp_mux
 * Picks, for one initiator, the target response whose echoed id matches
 * that initiator. Responses cannot be stalled.
 */

`timescale 1ns/1ps

module periph_resp_mux
  import periph_xbar_pkg::*;
(
  input  logic        [NB_TGTS-1:0] rvalid_i,
  input  periph_rsp_t [NB_TGTS-1:0] rdata_i,
  input  init_id_t                  my_id_i,
  output logic                      rvalid_o,
  output periph_rsp_t               rdata_o
);

  logic [NB_TGTS-1:0] hit;
  tgt_idx_t           sel;

  for (genvar t = 0; t < NB_TGTS; t++) begin : gen_hit
    assign hit[t] = rvalid_i[t] && (rdata_i[t].id == my_id_i);
  end

  // at most one target answers an initiator per cycle, so OR-ing is enough
  always_comb begin
    sel = '0;
    for (int unsigned t = 0; t < NB_TGTS; t++) begin
      if (hit[t]) begin
        sel = sel | tgt_idx_t'(t);
      end
    end
  end

  assign rvalid_o = |hit;
  assign rdata_o  = rdata_i[sel];

endmodule

/* verilog/periph_xbar.sv */
/*
 * periph_xbar
 * Peripheral interconnect of the cluster. Routes core and master peripheral
 * requests to the slave peripherals through per-target round-robin arbiters
 * and returns responses by the echoed initiator id.
 */

`timescale 1ns/1ps

module periph_xbar
  import periph_xbar_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic        [5:0]         cluster_id_i,
  // initiator side
  input  logic        [NB_INPS-1:0] init_req_i,
  input  periph_req_t [NB_INPS-1:0] init_wdata_i,
  output logic        [NB_INPS-1:0] init_gnt_o,
  output logic        [NB_INPS-1:0] init_rvalid_o,
  output periph_rsp_t [NB_INPS-1:0] init_rdata_o,
  // target side
  output logic        [NB_TGTS-1:0] tgt_req_o,
  output periph_req_t [NB_TGTS-1:0] tgt_wdata_o,
  input  logic        [NB_TGTS-1:0] tgt_gnt_i,
  input  logic        [NB_TGTS-1:0] tgt_rvalid_i,
  input  periph_rsp_t [NB_TGTS-1:0] tgt_rdata_i
);

  logic [ADDR_W-1:0] cluster_base;
  logic [ADDR_W-1:0] periph_base;
  logic [ADDR_W-1:0] periph_end;

  // address window, computed once for all routers
  assign cluster_base = CLUSTER_BASE + (ADDR_W'(cluster_id_i) << 22);
  assign periph_base  = cluster_base + PERIPH_OFFS;
  assign periph_end   = cluster_base + EXT_OFFS;

  periph_req_t [NB_INPS-1:0]              req_payload;
  logic [NB_INPS-1:0][NB_TGTS-1:0]        route_req;
  logic [NB_INPS-1:0][NB_TGTS-1:0]        route_gnt;
  logic [NB_TGTS-1:0][NB_INPS-1:0]        arb_req;
  logic [NB_TGTS-1:0][NB_INPS-1:0]        arb_gnt;

  for (genvar i = 0; i < NB_INPS; i++) begin : gen_inps
    // the id is always the initiator's own one-hot position
    assign req_payload[i] = '{
      addr: init_wdata_i[i].addr,
      data: init_wdata_i[i].data,
      id:   init_id_t'(1 << i),
      we_n: init_wdata_i[i].we_n,
      be:   init_wdata_i[i].be
    };

    periph_req_router u_router (
      .periph_base_i (periph_base),
      .periph_end_i  (periph_end),
      .cluster_top_i (cluster_base[31:24]),
      .req_i         (init_req_i[i]),
      .addr_i        (init_wdata_i[i].addr),
      .tgt_gnt_i     (route_gnt[i]),
      .tgt_req_o     (route_req[i]),
      .gnt_o         (init_gnt_o[i])
    );

    periph_resp_mux u_resp_mux (
      .rvalid_i (tgt_rvalid_i),
      .rdata_i  (tgt_rdata_i),
      .my_id_i  (init_id_t'(1 << i)),
      .rvalid_o (init_rvalid_o[i]),
      .rdata_o  (init_rdata_o[i])
    );
  end

  for (genvar t = 0; t < NB_TGTS; t++) begin : gen_tgts
    // transpose initiator x target into target x initiator
    for (genvar i = 0; i < NB_INPS; i++) begin : gen_xpose
      assign arb_req[t][i]   = route_req[i][t];
      assign route_gnt[i][t] = arb_gnt[t][i];
    end

    periph_rr_arb u_arb (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .req_i  (arb_req[t]),
      .data_i (req_payload),
      .gnt_i  (tgt_gnt_i[t]),
      .gnt_o  (arb_gnt[t]),
      .req_o  (tgt_req_o[t]),
      .data_o (tgt_wdata_o[t])
    );
  end

endmodule

/* bench/tb_clk_gen.sv */
/*
 * tb_clk_gen
 * Free-running 40 ns clock and a reset held for the first three cycles.
 */

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  logic clk = 1'b0;
  logic rst = 1'b1;

  assign clk_o = clk;
  assign rst_o = rst;

  always #20 clk = ~clk;

  initial begin
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* bench/periph_xbar_tb.sv */
/*
 * periph_xbar_tb
 * Four initiators drive the peripheral interconnect while eight target
 * models grant at random and answer later. Checks decode, payload, grants,
 * round-robin order and response routing.
 */

`timescale 1ns/1ps

module periph_xbar_tb
  import periph_xbar_pkg::*;
();

  localparam int unsigned REQS_PER_INP   = 150;
  localparam int unsigned TIMEOUT_CYCLES = 8000;
  localparam int unsigned SEED           = 92242;
  localparam logic [31:0] CL_BASE  = CLUSTER_BASE + (32'd1 << 22);
  localparam logic [31:0] P_BASE   = CL_BASE + PERIPH_OFFS;
  localparam logic [31:0] P_END    = CL_BASE + EXT_OFFS;
  localparam logic [31:0] RSP_MASK = 32'h5A5A_5A5A;

  logic clk;
  logic rst;

  logic        [NB_INPS-1:0] init_req   = '0;
  periph_req_t [NB_INPS-1:0] init_wdata = '0;
  logic        [NB_INPS-1:0] init_gnt;
  logic        [NB_INPS-1:0] init_rvalid;
  periph_rsp_t [NB_INPS-1:0] init_rdata;
  logic        [NB_TGTS-1:0] tgt_req;
  periph_req_t [NB_TGTS-1:0] tgt_wdata;
  logic        [NB_TGTS-1:0] tgt_gnt    = '0;
  logic        [NB_TGTS-1:0] tgt_rvalid = '0;
  periph_rsp_t [NB_TGTS-1:0] tgt_rdata  = '0;
  logic        [5:0]         cluster_id = 6'd1;

  // initiator side scoreboard
  int           issued    [NB_INPS];
  int           grants    [NB_INPS];
  int           resps     [NB_INPS];
  bit [NB_INPS-1:0] passed_by [NB_INPS];
  bit           waiting   [NB_INPS];
  logic [31:0]  exp_data  [NB_INPS];
  bit           exp_opc   [NB_INPS];
  // accepted requests held by the target models, one per initiator at most
  bit          mdl_vld  [NB_INPS];
  int          mdl_tgt  [NB_INPS];
  int          mdl_due  [NB_INPS];
  periph_rsp_t mdl_rsp  [NB_INPS];
  int          gcount   [NB_TGTS];

  int errors       = 0;
  int cycle        = 0;
  bit idle_checked = 1'b0;
  bit all_done     = 1'b0;
  int d;
  int owner;
  int tot_gnt;
  int tot_rsp;

  logic        [NB_INPS-1:0] nxt_req;
  periph_req_t [NB_INPS-1:0] nxt_wdata;
  logic        [NB_TGTS-1:0] nxt_gnt;
  logic        [NB_TGTS-1:0] nxt_rvalid;
  periph_rsp_t [NB_TGTS-1:0] nxt_rdata;
  logic        [NB_INPS-1:0] busy;

  tb_clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  periph_xbar UUT (
    .clk_i         (clk),
    .rst_i         (rst),
    .cluster_id_i  (cluster_id),
    .init_req_i    (init_req),
    .init_wdata_i  (init_wdata),
    .init_gnt_o    (init_gnt),
    .init_rvalid_o (init_rvalid),
    .init_rdata_o  (init_rdata),
    .tgt_req_o     (tgt_req),
    .tgt_wdata_o   (tgt_wdata),
    .tgt_gnt_i     (tgt_gnt),
    .tgt_rvalid_i  (tgt_rvalid),
    .tgt_rdata_i   (tgt_rdata)
  );

  task automatic compare_hex(string name, logic [72:0] got, logic [72:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic ensure(bit cond, string what);
    assert (cond) else begin
      errors++;
      $display("ERROR: %s", what);
    end
  endtask

  // address map of cluster 1, independent of the router
  function automatic int ref_decode(logic [31:0] a);
    logic [3:0] idx;
    idx = a[13:10];
    if (!(a[31:24] == CL_BASE[31:24] || a[31:24] == 8'h1B) || a < P_BASE || a > P_END)
      return 6;
    if (a[31:20] != P_BASE[31:20] || a[19:14] != 6'd0 || idx >= 4'd8)
      return 7;
    if (idx == 4'd2 || idx == 4'd3)
      return 2;
    if (idx == 4'd5 || idx == 4'd6)
      return 7;
    return int'(idx);
  endfunction

  function automatic int idx_of(init_id_t id);
    int r;
    r = 0;
    for (int k = 0; k < NB_INPS; k++) begin
      if (id[k])
        r = k;
    end
    return r;
  endfunction

  function automatic logic [31:0] pick_addr(int n);
    logic [31:0] a;
    int unsigned kind;
    kind = $urandom % 16;
    a = P_BASE | (32'($urandom % 16) << ROUTE_LSB) | ($urandom & 32'h3FC);
    if ((n / 15) % 4 == 3) begin
      // burst, every initiator aims at the same peripheral
      a = P_BASE | (((n < 60) ? 32'd3 : 32'd0) << ROUTE_LSB);
    end else if (kind >= 14) begin
      a = {16'h1B20, 16'($urandom)};
    end else if (kind == 13) begin
      a = 32'h2000_0000 | ($urandom & 32'h0FFF_FFFC);
    end else if (kind >= 11) begin
      a = a | ((1 + $urandom % 63) << 14);
    end
    return a;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      ensure(tgt_req == '0 && init_gnt == '0 && init_rvalid == '0,
             "interconnect outputs active during reset");
    end else if (!idle_checked) begin
      ensure(tgt_req == '0 && init_gnt == '0 && init_rvalid == '0,
             "interconnect outputs active in the idle cycle after reset");
      void'($urandom(SEED));
      idle_checked = 1'b1;
    end else begin
      cycle++;
      nxt_req    = init_req;
      nxt_wdata  = init_wdata;
      nxt_rvalid = '0;
      nxt_rdata  = '0;
      busy       = '0;

      for (int i = 0; i < NB_INPS; i++) begin
        if (init_rvalid[i]) begin
          ensure(waiting[i], $sformatf("initiator %0d got a response it never asked for", i));
          compare_hex($sformatf("init_rdata_o[%0d].data", i), init_rdata[i].data, exp_data[i]);
          compare_hex($sformatf("init_rdata_o[%0d].id", i), init_rdata[i].id,
                      init_id_t'(1 << i));
          compare_hex($sformatf("init_rdata_o[%0d].opc", i), init_rdata[i].opc, exp_opc[i]);
          resps[i]++;
          waiting[i] = 1'b0;
        end
      end

      // target side handshakes, the models accept and schedule an answer
      for (int t = 0; t < NB_TGTS; t++) begin
        gcount[t] = 0;
        if (tgt_req[t] && tgt_gnt[t]) begin
          owner = idx_of(tgt_wdata[t].id);
          compare_hex($sformatf("decode of tgt_wdata_o[%0d].addr", t),
                      ref_decode(tgt_wdata[t].addr), t);
          ensure($onehot(tgt_wdata[t].id) && init_gnt[owner],
                 $sformatf("target %0d accepted a request with no granted owner", t));
          compare_hex($sformatf("tgt_wdata_o[%0d].addr", t), tgt_wdata[t].addr,
                      init_wdata[owner].addr);
          compare_hex($sformatf("tgt_wdata_o[%0d].data", t), tgt_wdata[t].data,
                      init_wdata[owner].data);
          compare_hex($sformatf("tgt_wdata_o[%0d].we_n", t), tgt_wdata[t].we_n,
                      init_wdata[owner].we_n);
          compare_hex($sformatf("tgt_wdata_o[%0d].be", t), tgt_wdata[t].be,
                      init_wdata[owner].be);
          mdl_vld[owner] = 1'b1;
          mdl_tgt[owner] = t;
          mdl_due[owner] = cycle + int'($urandom % 3);
          mdl_rsp[owner] = '{data: tgt_wdata[t].addr ^ 32'(t) ^ RSP_MASK,
                             id: tgt_wdata[t].id, opc: tgt_wdata[t].we_n};
        end
      end

      for (int i = 0; i < NB_INPS; i++) begin
        if (init_gnt[i]) begin
          d = ref_decode(init_wdata[i].addr);
          ensure(init_req[i] && tgt_req[d] && tgt_gnt[d],
                 $sformatf("initiator %0d granted without a handshake at target %0d", i, d));
          gcount[d]++;
          grants[i]++;
          waiting[i]   = 1'b1;
          passed_by[i] = '0;
          exp_data[i]  = init_wdata[i].addr ^ 32'(d) ^ RSP_MASK;
          exp_opc[i]   = init_wdata[i].we_n;
          nxt_req[i]   = 1'b0;
          // a waiting initiator may be passed by each other initiator only once
          for (int j = 0; j < NB_INPS; j++) begin
            if (j != i && init_req[j] && !init_gnt[j] &&
                ref_decode(init_wdata[j].addr) == d) begin
              ensure(!passed_by[j][i],
                     $sformatf("initiator %0d granted twice at target %0d while %0d waited",
                               i, d, j));
              passed_by[j][i] = 1'b1;
            end
          end
        end
      end

      for (int t = 0; t < NB_TGTS; t++) begin
        ensure(gcount[t] == int'(tgt_req[t] && tgt_gnt[t]),
               $sformatf("target %0d has %0d initiator grants for its handshake", t, gcount[t]));
        // answer at most one due request, never two targets to one initiator
        for (int i = 0; i < NB_INPS; i++) begin
          if (!nxt_rvalid[t] && mdl_vld[i] && mdl_tgt[i] == t && cycle >= mdl_due[i] &&
              !busy[i]) begin
            nxt_rvalid[t] = 1'b1;
            nxt_rdata[t]  = mdl_rsp[i];
            mdl_vld[i]    = 1'b0;
            busy[i]       = 1'b1;
          end
        end
        nxt_gnt[t] = ($urandom % 10) < 7;
      end

      all_done = 1'b1;
      for (int i = 0; i < NB_INPS; i++) begin
        if (!nxt_req[i] && !waiting[i] && issued[i] < REQS_PER_INP && ($urandom % 4) != 0) begin
          nxt_req[i]   = 1'b1;
          nxt_wdata[i] = '{addr: pick_addr(issued[i]), data: DATA_W'($urandom),
                           id: init_id_t'($urandom), we_n: 1'($urandom), be: BE_W'($urandom)};
          issued[i]++;
        end
        if (issued[i] < REQS_PER_INP || nxt_req[i] || waiting[i] || mdl_vld[i])
          all_done = 1'b0;
      end

      init_req   <= nxt_req;
      init_wdata <= nxt_wdata;
      tgt_gnt    <= nxt_gnt;
      tgt_rvalid <= nxt_rvalid;
      tgt_rdata  <= nxt_rdata;
    end
  end

  initial begin
    tot_gnt = 0;
    tot_rsp = 0;
    while (!all_done && cycle < TIMEOUT_CYCLES)
      @(negedge clk);
    if (!all_done) begin
      errors++;
      $display("ERROR: traffic did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
    for (int i = 0; i < NB_INPS; i++) begin
      compare_hex($sformatf("response count of initiator %0d", i), resps[i], grants[i]);
      compare_hex($sformatf("grant count of initiator %0d", i), grants[i], REQS_PER_INP);
      tot_gnt += grants[i];
      tot_rsp += resps[i];
    end
    $display("errors %0d, grants %0d, responses %0d, cycles %0d",
             errors, tot_gnt, tot_rsp, cycle);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

/* tb.f */
verilog/periph_xbar_pkg.sv
verilog/periph_req_router.sv
verilog/periph_rr_arb.sv
verilog/periph_resp_mux.sv
verilog/periph_xbar.sv
bench/tb_clk_gen.sv
bench/periph_xbar_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the peripheral interconnect testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module periph_xbar_tb -o periph_xbar_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/periph_xbar_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
